//--- booth_mul/booth_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module booth_mul
	import mdu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      flush,
	input  logic      start,
	input  mul_req_t  req,
	output logic      idle,
	output logic      done,
	output mdu_wide_u result
);

	// operands carry one extra bit so unsigned fits as signed
	localparam int XLEN  = `MDU_XLEN;
	localparam int WLEN  = `MDU_WLEN;
	localparam int XW    = XLEN + 1;
	localparam int ACC_W = 2 * XW;
	// multiplier shift reg, two sign bits plus the implicit zero below
	localparam int YW    = XLEN + 3;
	localparam int CNT_W = $clog2(`MDU_MUL_STEPS + 1);

	logic             busy;
	logic [CNT_W-1:0] cnt;
	logic [ACC_W-1:0] acc;
	logic [XW-1:0]    x;
	logic [YW-1:0]    y;

	logic             a_msb;
	logic             b_msb;
	logic [XW-1:0]    x_ext;
	logic [YW-1:0]    y_ext;
	logic [ACC_W-1:0] x_wide;
	logic [ACC_W-1:0] pp;
	logic [ACC_W-1:0] acc_next;

	assign idle = ~busy;

	// ********************
	// operand extension
	// ********************
	always_comb begin
		if (req.word) begin
			a_msb = req.a_signed & req.a[WLEN-1];
			b_msb = req.b_signed & req.b[WLEN-1];
			x_ext = {{(XW - WLEN){a_msb}}, req.a[WLEN-1:0]};
			// top digit of the word form lands in the top three bits
			y_ext = {{2{b_msb}}, req.b[WLEN-1:0], {(WLEN + 1){1'b0}}};
		end else begin
			a_msb = req.a_signed & req.a[XLEN-1];
			b_msb = req.b_signed & req.b[XLEN-1];
			x_ext = {a_msb, req.a};
			y_ext = {{2{b_msb}}, req.b, 1'b0};
		end
	end

	// ********************
	// booth digit
	// ********************
	always_comb begin
		x_wide = {{(ACC_W - XW){x[XW-1]}}, x};
		// digit taken msb first, horner form
		case (y[YW-1 -: 3])
			3'b001, 3'b010: pp = x_wide;
			3'b011:         pp = x_wide << 1;
			3'b100:         pp = -(x_wide << 1);
			3'b101, 3'b110: pp = -x_wide;
			default:        pp = '0;
		endcase
		acc_next = (acc << 2) + pp;
	end

	// control
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start && !busy) begin
				busy <= 1'b1;
			end else if (busy && cnt == '0) begin
				// last digit added this cycle
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (start && !busy) begin
			x   <= x_ext;
			y   <= y_ext;
			acc <= '0;
			// one more digit than steps for the extension bit
			cnt <= req.word ? CNT_W'(`MDU_MUL_STEPS_W) : CNT_W'(`MDU_MUL_STEPS);
		end else if (busy) begin
			acc <= acc_next;
			y   <= y << 2;
			cnt <= cnt - 1'b1;
			if (cnt == '0) begin
				result.prod.hi <= acc_next[2*XLEN-1:XLEN];
				result.prod.lo <= acc_next[XLEN-1:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- common/mdu_defs.svh
`ifndef MDU_DEFS_SVH
`define MDU_DEFS_SVH

// ********************
// datapath widths
// ********************

// operand width of the core
`define MDU_XLEN 64

// word-form operand width
`define MDU_WLEN (`MDU_XLEN / 2)

// ********************
// iteration counts
// ********************

// booth radix-4 steps for a full-width multiply
`define MDU_MUL_STEPS 32

// word multiply, half the steps
`define MDU_MUL_STEPS_W (`MDU_MUL_STEPS / 2)

// one quotient bit per step
`define MDU_DIV_STEPS 64

// word divide
`define MDU_DIV_STEPS_W (`MDU_DIV_STEPS / 2)

`endif

//--- common/mdu_pkg.sv
`default_nettype none

`include "mdu_defs.svh"

package mdu_pkg;

	// ********************
	// request / response
	// ********************

	// op code is the funct3 field of the M extension
	typedef enum logic [2:0] {
		OP_MUL    = 3'b000,
		OP_MULH   = 3'b001,
		OP_MULHSU = 3'b010,
		OP_MULHU  = 3'b011,
		OP_DIV    = 3'b100,
		OP_DIVU   = 3'b101,
		OP_REM    = 3'b110,
		OP_REMU   = 3'b111
	} mdu_op_e;

	typedef struct packed {
		mdu_op_e              op;
		logic                 word;
		logic [`MDU_XLEN-1:0] a;
		logic [`MDU_XLEN-1:0] b;
	} mdu_req_t;

	typedef struct packed {
		logic [`MDU_XLEN-1:0] value;
	} mdu_rsp_t;

	// ********************
	// engine side
	// ********************

	typedef struct packed {
		logic [`MDU_XLEN-1:0] a;
		logic [`MDU_XLEN-1:0] b;
		logic                 a_signed;
		logic                 b_signed;
		logic                 word;
	} mul_req_t;

	typedef struct packed {
		logic [`MDU_XLEN-1:0] dividend;
		logic [`MDU_XLEN-1:0] divisor;
		logic                 is_signed;
		logic                 word;
	} div_req_t;

	// product halves
	typedef struct packed {
		logic [`MDU_XLEN-1:0] hi;
		logic [`MDU_XLEN-1:0] lo;
	} mdu_prod_t;

	// remainder on top, quotient below
	typedef struct packed {
		logic [`MDU_XLEN-1:0] rem;
		logic [`MDU_XLEN-1:0] quo;
	} mdu_qr_t;

	// one 128-bit result word, read per engine
	typedef union packed {
		mdu_prod_t prod;
		mdu_qr_t   qr;
	} mdu_wide_u;

endpackage

`default_nettype wire

//--- dv/mdu_stimulus.txt
# columns: op (funct3, 0 mul .. 7 remu) word a b expected flush_cycle
# operands and expected value in hex, flush_cycle 0 means the op runs to the end
0 0 0000000000000007 0000000000000006 000000000000002a 0
0 0 fffffffffffffffd 0000000000000005 fffffffffffffff1 0
0 0 123456789abcdef0 0000000000000010 23456789abcdef00 0
0 0 ffffffffffffffff ffffffffffffffff 0000000000000001 0
1 0 ffffffffffffffff ffffffffffffffff 0000000000000000 0
1 0 8000000000000000 8000000000000000 4000000000000000 0
1 0 fffffffffffffffd 0000000000000005 ffffffffffffffff 0
1 0 7fffffffffffffff 7fffffffffffffff 3fffffffffffffff 0
2 0 ffffffffffffffff ffffffffffffffff ffffffffffffffff 0
2 0 0000000000000002 8000000000000000 0000000000000001 0
2 0 fffffffffffffffe 8000000000000000 ffffffffffffffff 0
3 0 ffffffffffffffff ffffffffffffffff fffffffffffffffe 0
3 0 0000000100000000 0000000100000000 0000000000000001 0
0 0 0000000000000003 0000000000000005 000000000000000f 20
3 0 8000000000000000 0000000000000004 0000000000000002 0
4 0 0000000000000064 0000000000000007 000000000000000e 0
4 0 ffffffffffffff9c 0000000000000007 fffffffffffffff2 0
4 0 0000000000000005 0000000000000000 ffffffffffffffff 0
4 0 8000000000000000 ffffffffffffffff 8000000000000000 0
4 0 0000000000000064 fffffffffffffff9 fffffffffffffff2 0
5 0 ffffffffffffffff 0000000000000002 7fffffffffffffff 0
5 0 0000000000000001 0000000000000000 ffffffffffffffff 0
4 0 ffffffffffffff9c 0000000000000007 fffffffffffffff2 40
5 0 8000000000000000 ffffffffffffffff 0000000000000000 0
6 0 0000000000000064 0000000000000007 0000000000000002 0
6 0 ffffffffffffff9c 0000000000000007 fffffffffffffffe 0
6 0 ffffffffffffff9c 0000000000000000 ffffffffffffff9c 0
6 0 8000000000000000 ffffffffffffffff 0000000000000000 0
7 0 ffffffffffffffff 000000000000000a 0000000000000005 0
7 0 0000000000000007 0000000000000000 0000000000000007 0
3 0 ffffffffffffffff ffffffffffffffff fffffffffffffffe 1
0 1 000000007fffffff 0000000000000002 fffffffffffffffe 0
0 1 ffffffff00000003 1234567800000005 000000000000000f 0
4 1 00000000ffffff9c 0000000000000007 fffffffffffffff2 0
4 1 0000000080000000 00000000ffffffff ffffffff80000000 0
4 1 0000000012345678 ffffffff00000000 ffffffffffffffff 0
5 1 00000000ffffffff 0000000000000002 000000007fffffff 0
4 1 00000000ffffff9c 0000000000000007 fffffffffffffff2 10
5 1 0000000080000000 0000000000000001 ffffffff80000000 0
6 1 00000000ffffff9c 0000000000000007 fffffffffffffffe 0
6 1 1234567887654321 0000000000000000 ffffffff87654321 0
7 1 00000000ffffffff 0000000000000010 000000000000000f 0
7 1 0000000080000005 0000000080000000 0000000000000005 0

//--- dv/tb_mdu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module tb_mdu
	import mdu_pkg::*;
();

	localparam int    CLK_PERIOD   = 40;
	localparam int    RST_CYCLES   = 4;
	// a full divide is the longest op at about 70 cycles
	localparam int    WAIT_LIMIT   = 4 * `MDU_DIV_STEPS;
	// quiet window after a flush that outlasts any engine run
	localparam int    QUIET_CYCLES = `MDU_DIV_STEPS + 8;
	localparam int    SEED         = 34;
	localparam string STIM_FILE    = "dv/mdu_stimulus.txt";

	logic     clk;
	logic     rst;
	logic     flush;
	mdu_req_t req;
	logic     req_valid;
	logic     req_ready;
	mdu_rsp_t rsp;
	logic     rsp_valid;
	logic     rsp_ready;

	// test bookkeeping
	int n_tests;
	int n_bad;
	// set when a wait runs out or the file is unusable
	bit broken;

	mdu_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.flush     (flush),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rsp       (rsp),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ********************
	// compare tasks
	// ********************

	// single control bit
	task automatic check_ctrl(input logic got, input logic exp, input string what,
		inout bit ok);
		if (got !== exp) begin
			$display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
			ok = 1'b0;
		end
	endtask

	// response word
	task automatic check_rsp(input mdu_rsp_t got, input mdu_rsp_t exp, input string what,
		inout bit ok);
		if (got !== exp) begin
			$display("FAILED %0t: %s is %h, expected %h", $time, what, got.value, exp.value);
			ok = 1'b0;
		end
	endtask

	// ********************
	// bounded waits
	// ********************
	task automatic wait_req_ready(output bit seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge clk);
			if (req_ready) begin
				seen = 1'b1;
				break;
			end
		end
	endtask

	task automatic wait_rsp_valid(output bit seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge clk);
			if (rsp_valid) begin
				seen = 1'b1;
				break;
			end
		end
	endtask

	// after a flush ready comes straight back and no response ever shows
	task automatic check_flushed(inout bit ok);
		int n;
		bit back;
		back = 1'b0;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			check_ctrl(rsp_valid, 1'b0, "rsp_valid after flush", ok);
			if (req_ready) begin
				back = 1'b1;
				break;
			end
			@(negedge clk);
		end
		if (!back) begin
			$display("req_ready never returned after the flush");
			broken = 1'b1;
			ok = 1'b0;
		end else begin
			if (n != 0) begin
				$display("FAILED %0t: req_ready back %0d cycles late after flush", $time, n);
				ok = 1'b0;
			end
			for (n = 0; n < QUIET_CYCLES; n++) begin
				@(negedge clk);
				check_ctrl(rsp_valid, 1'b0, "rsp_valid after flush", ok);
			end
		end
	endtask

	// ********************
	// one request
	// ********************
	task automatic run_test(input int idx, input mdu_req_t r, input mdu_rsp_t exp,
		input int flush_at);
		bit       ok;
		bit       seen;
		mdu_rsp_t held;
		int       stall;
		int       n;
		ok = 1'b1;
		wait_req_ready(seen);
		if (!seen) begin
			$display("test %0d: req_ready stayed low, the request was never taken", idx);
			broken = 1'b1;
			return;
		end
		// ready seen at this falling edge so the next rising edge accepts
		req       = r;
		req_valid = 1'b1;
		@(negedge clk);
		req_valid = 1'b0;
		check_ctrl(req_ready, 1'b0, "req_ready after accept", ok);
		if (flush_at > 0) begin
			// flush_at counts cycles after acceptance
			repeat (flush_at - 1) @(negedge clk);
			flush = 1'b1;
			@(negedge clk);
			flush = 1'b0;
			check_flushed(ok);
		end else begin
			wait_rsp_valid(seen);
			if (!seen) begin
				$display("test %0d: rsp_valid never rose", idx);
				broken = 1'b1;
				return;
			end
			held = rsp;
			check_ctrl(req_ready, 1'b0, "req_ready with rsp_valid", ok);
			// random back-pressure of 0 to 3 cycles
			stall = int'($urandom % 4);
			for (n = 0; n < stall; n++) begin
				@(negedge clk);
				check_rsp(rsp, held, "rsp under stall", ok);
				check_ctrl(rsp_valid, 1'b1, "rsp_valid under stall", ok);
				check_ctrl(req_ready, 1'b0, "req_ready under stall", ok);
			end
			check_rsp(held, exp, "result", ok);
			rsp_ready = 1'b1;
			@(negedge clk);
			rsp_ready = 1'b0;
			check_ctrl(rsp_valid, 1'b0, "rsp_valid after handshake", ok);
		end
		n_tests++;
		if (!ok) begin
			n_bad++;
		end
		$display("test %0d: op %0d word %0d flush %0d %s", idx, r.op, r.word, flush_at,
			ok ? "ok" : "error");
	endtask

	// ********************
	// main sequence
	// ********************
	initial begin
		int                   fd;
		int                   cnt;
		int                   idx;
		int                   flush_v;
		string                line;
		logic [2:0]           op_v;
		logic                 word_v;
		logic [`MDU_XLEN-1:0] a_v;
		logic [`MDU_XLEN-1:0] b_v;
		logic [`MDU_XLEN-1:0] exp_v;
		mdu_req_t             r;
		mdu_rsp_t             exp;
		bit                   ok;

		clk       = 1'b0;
		rst       = 1'b1;
		flush     = 1'b0;
		req       = '0;
		req_valid = 1'b0;
		rsp_ready = 1'b0;
		n_tests   = 0;
		n_bad     = 0;
		broken    = 1'b0;
		void'($urandom(SEED));

		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// reset state
		ok = 1'b1;
		check_ctrl(rsp_valid, 1'b0, "rsp_valid after reset", ok);
		check_ctrl(req_ready, 1'b1, "req_ready after reset", ok);
		n_tests++;
		if (!ok) begin
			n_bad++;
		end
		$display("test 0: reset state %s", ok ? "ok" : "error");

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("could not open stimulus file %s", STIM_FILE);
			broken = 1'b1;
		end
		idx = 1;
		while (fd != 0 && !broken && !$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) == 0) begin
				break;
			end
			// comment and blank lines
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			cnt = $sscanf(line, "%h %h %h %h %h %d", op_v, word_v, a_v, b_v, exp_v, flush_v);
			if (cnt != 6) begin
				$display("stimulus entry %0d has a bad format", idx);
				broken = 1'b1;
			end else begin
				r.op      = mdu_op_e'(op_v);
				r.word    = word_v;
				r.a       = a_v;
				r.b       = b_v;
				exp.value = exp_v;
				run_test(idx, r, exp, flush_v);
				idx++;
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("%0d tests run, %0d ok, %0d with errors", n_tests, n_tests - n_bad, n_bad);
		if (n_bad == 0 && !broken && n_tests > 1) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+common
common/mdu_pkg.sv
booth_mul/booth_mul.sv
nr_div/nr_div.sv
verilog/mdu_sequencer.sv
verilog/mdu_top.sv
dv/tb_mdu.sv

//--- nr_div/nr_div.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module nr_div
	import mdu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      flush,
	input  logic      start,
	input  div_req_t  req,
	output logic      idle,
	output logic      done,
	output mdu_wide_u result
);

	localparam int XLEN  = `MDU_XLEN;
	localparam int WLEN  = `MDU_WLEN;
	localparam int CNT_W = $clog2(`MDU_DIV_STEPS);

	typedef enum logic [1:0] {
		D_IDLE,
		D_ITER,
		D_FIX,
		D_SIGN
	} div_state_e;

	div_state_e       state;
	logic [CNT_W-1:0] cnt;
	// signed partial remainder one bit wider than the divisor
	logic [XLEN:0]    r;
	logic [XLEN-1:0]  q;
	logic [XLEN-1:0]  d;
	logic             neg_q;
	logic             neg_r;

	logic             sign_a;
	logic             sign_b;
	logic [XLEN-1:0]  a_ext;
	logic [XLEN-1:0]  b_ext;
	logic [XLEN-1:0]  a_mag;
	logic [XLEN-1:0]  b_mag;
	logic             div_zero;
	logic             div_ovf;
	logic [XLEN:0]    r_shift;
	logic [XLEN:0]    r_step;

	assign idle = (state == D_IDLE);

	// ********************
	// operand prep
	// ********************
	always_comb begin
		if (req.word) begin
			sign_a  = req.is_signed & req.dividend[WLEN-1];
			sign_b  = req.is_signed & req.divisor[WLEN-1];
			a_ext   = {{(XLEN - WLEN){sign_a}}, req.dividend[WLEN-1:0]};
			b_ext   = {{(XLEN - WLEN){sign_b}}, req.divisor[WLEN-1:0]};
			div_ovf = req.dividend[WLEN-1:0] == {1'b1, {(WLEN - 1){1'b0}}};
		end else begin
			sign_a  = req.is_signed & req.dividend[XLEN-1];
			sign_b  = req.is_signed & req.divisor[XLEN-1];
			a_ext   = req.dividend;
			b_ext   = req.divisor;
			div_ovf = req.dividend == {1'b1, {(XLEN - 1){1'b0}}};
		end
		// most negative over -1
		div_ovf  = div_ovf & req.is_signed & (&b_ext);
		div_zero = (b_ext == '0);
		a_mag    = sign_a ? -a_ext : a_ext;
		b_mag    = sign_b ? -b_ext : b_ext;
	end

	// one non-restoring step where the sign of r picks add or subtract
	always_comb begin
		r_shift = {r[XLEN-1:0], q[XLEN-1]};
		r_step  = r[XLEN] ? r_shift + {1'b0, d} : r_shift - {1'b0, d};
	end

	// ********************
	// control FSM
	// ********************
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state <= D_IDLE;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				D_IDLE: begin
					if (start) begin
						// short cut with no iterations
						if (div_zero || div_ovf) begin
							done <= 1'b1;
						end else begin
							state <= D_ITER;
						end
					end
				end
				D_ITER: begin
					if (cnt == '0) begin
						state <= D_FIX;
					end
				end
				D_FIX: begin
					state <= D_SIGN;
				end
				D_SIGN: begin
					state <= D_IDLE;
					done  <= 1'b1;
				end
				default: begin
					state <= D_IDLE;
				end
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		case (state)
			D_IDLE: begin
				if (start) begin
					r     <= '0;
					d     <= b_mag;
					neg_q <= sign_a ^ sign_b;
					neg_r <= sign_a;
					// word dividend sits high so its msb shifts out first
					if (req.word) begin
						q   <= {a_mag[WLEN-1:0], {(XLEN - WLEN){1'b0}}};
						cnt <= CNT_W'(`MDU_DIV_STEPS_W - 1);
					end else begin
						q   <= a_mag;
						cnt <= CNT_W'(`MDU_DIV_STEPS - 1);
					end
					if (div_zero) begin
						result.qr.quo <= '1;
						result.qr.rem <= req.dividend;
					end else if (div_ovf) begin
						result.qr.quo <= req.dividend;
						result.qr.rem <= '0;
					end
				end
			end
			D_ITER: begin
				r   <= r_step;
				q   <= {q[XLEN-2:0], ~r_step[XLEN]};
				cnt <= cnt - 1'b1;
			end
			D_FIX: begin
				// negative remainder gets the divisor back
				if (r[XLEN]) begin
					r <= r + {1'b0, d};
				end
			end
			D_SIGN: begin
				result.qr.quo <= neg_q ? -q : q;
				result.qr.rem <= neg_r ? -r[XLEN-1:0] : r[XLEN-1:0];
			end
		endcase
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the mdu testbench with verilator and run it
# exit status is 0 only when the log holds the pass message

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
TOP=tb_mdu

verilator --binary --timing -Wno-fatal \
	-f filelist.f \
	--top-module "$TOP" \
	-Mdir "$OBJ_DIR" \
	-o "$TOP"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TESTS PASSED" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi

//--- verilog/mdu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_sequencer
	import mdu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      flush,
	input  mdu_req_t  req,
	input  logic      req_valid,
	output logic      req_ready,
	output mdu_rsp_t  rsp,
	output logic      rsp_valid,
	input  logic      rsp_ready,
	output logic      mul_start,
	output mul_req_t  mul_req,
	input  logic      mul_idle,
	input  logic      mul_done,
	input  mdu_wide_u mul_result,
	output logic      div_start,
	output div_req_t  div_req,
	input  logic      div_idle,
	input  logic      div_done,
	input  mdu_wide_u div_result
);

	localparam int XLEN = `MDU_XLEN;
	localparam int WLEN = `MDU_WLEN;

	typedef enum logic [1:0] {
		S_IDLE,
		S_BUSY,
		S_HOLD
	} seq_state_e;

	seq_state_e      state;
	mdu_op_e         op_q;
	logic            word_q;

	logic            accept;
	logic            req_is_div;
	logic            a_signed;
	logic            b_signed;
	logic            eng_done;
	logic [XLEN-1:0] pick;
	logic [XLEN-1:0] rsp_value;

	// ********************
	// decode
	// ********************
	assign req_is_div = req.op[2];

	always_comb begin
		case (req.op)
			OP_MULHSU: begin
				a_signed = 1'b1;
				b_signed = 1'b0;
			end
			OP_MULHU: begin
				a_signed = 1'b0;
				b_signed = 1'b0;
			end
			// MUL low half does not care
			default: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
			end
		endcase
	end

	// both engines idle, nothing in flight
	assign req_ready = (state == S_IDLE) && mul_idle && div_idle;
	assign accept    = req_valid && req_ready;
	assign rsp_valid = (state == S_HOLD);
	assign eng_done  = op_q[2] ? div_done : mul_done;

	// ********************
	// result merge
	// ********************
	always_comb begin
		if (!op_q[2]) begin
			pick = (op_q == OP_MUL) ? mul_result.prod.lo : mul_result.prod.hi;
		end else begin
			pick = op_q[1] ? div_result.qr.rem : div_result.qr.quo;
		end
		// word forms sign-extend bit 31
		rsp_value = word_q ? {{(XLEN - WLEN){pick[WLEN-1]}}, pick[WLEN-1:0]} : pick;
	end

	// FSM, flush drops everything
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state     <= S_IDLE;
			mul_start <= 1'b0;
			div_start <= 1'b0;
		end else begin
			mul_start <= accept && !req_is_div;
			div_start <= accept && req_is_div;
			case (state)
				S_IDLE: if (accept) state <= S_BUSY;
				S_BUSY: if (eng_done) state <= S_HOLD;
				S_HOLD: if (rsp_ready) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q    <= req.op;
			word_q  <= req.word;
			mul_req <= '{a: req.a, b: req.b, a_signed: a_signed, b_signed: b_signed,
				word: req.word};
			div_req <= '{dividend: req.a, divisor: req.b, is_signed: ~req.op[0],
				word: req.word};
		end
		if (state == S_BUSY && eng_done) begin
			rsp.value <= rsp_value;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mdu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mdu_top
	import mdu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     flush,
	input  mdu_req_t req,
	input  logic     req_valid,
	output logic     req_ready,
	output mdu_rsp_t rsp,
	output logic     rsp_valid,
	input  logic     rsp_ready
);

	// multiplier side
	logic      mul_start;
	mul_req_t  mul_req;
	logic      mul_idle;
	logic      mul_done;
	mdu_wide_u mul_result;

	// divider side
	logic      div_start;
	div_req_t  div_req;
	logic      div_idle;
	logic      div_done;
	mdu_wide_u div_result;

	// ********************
	// sequencer
	// ********************
	mdu_sequencer i_seq (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.rsp        (rsp),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready),
		.mul_start  (mul_start),
		.mul_req    (mul_req),
		.mul_idle   (mul_idle),
		.mul_done   (mul_done),
		.mul_result (mul_result),
		.div_start  (div_start),
		.div_req    (div_req),
		.div_idle   (div_idle),
		.div_done   (div_done),
		.div_result (div_result)
	);

	// ********************
	// engines, flush goes straight in
	// ********************
	booth_mul i_mul (
		.clk    (clk),
		.rst    (rst),
		.flush  (flush),
		.start  (mul_start),
		.req    (mul_req),
		.idle   (mul_idle),
		.done   (mul_done),
		.result (mul_result)
	);

	nr_div i_div (
		.clk    (clk),
		.rst    (rst),
		.flush  (flush),
		.start  (div_start),
		.req    (div_req),
		.idle   (div_idle),
		.done   (div_done),
		.result (div_result)
	);

endmodule

`default_nettype wire
